// File: build.f
+incdir+.
gfx_pkg.sv
gfx_strip_if.sv
gfx_calc_address.sv
gfx_strip_ram.sv
gfx_pixel_merge.sv
gfx_plot_ctrl.sv
gfx_plot_top.sv
tb_gfx_plot.sv

// File: gfx_calc_address.sv
// Turns the held pixel coordinates into a strip byte address and the pixel's bit field for the controller
`include "gfx_settings.svh"

module gfx_calc_address (
	input  logic                 clk,
	input  gfx_pkg::gfx_addr_t   base_address_i,
	input  gfx_pkg::gfx_depth_e  color_depth_i,
	input  gfx_pkg::gfx_coord_t  bmp_width_i,
	input  gfx_pkg::gfx_coord_t  x_coord_i,
	input  gfx_pkg::gfx_coord_t  y_coord_i,
	output gfx_pkg::gfx_addr_t   address_o,
	output gfx_pkg::gfx_bitpos_t mb_o,
	output gfx_pkg::gfx_bitpos_t me_o,
	output gfx_pkg::gfx_bitpos_t ce_o
);
	import gfx_pkg::*;

	logic [15:0] coeff;
	gfx_bitpos_t bpp;
	gfx_bitpos_t cbpp;
	logic [7:0]  strip_bits;
	gfx_addr_t   strip_num65k;
	logic [15:0] strip_fract;
	logic [15:0] ndx;
	gfx_addr_t   num_strips65k;
	gfx_addr_t   strip_count;

	// ========================================================================
	// Depth lookups
	// ========================================================================

	// Reciprocal of pixels per strip with 16 fraction bits
	always_comb begin
		case (color_depth_i)
			BPP4:    coeff = 16'd2048;
			BPP8:    coeff = 16'd4096;
			BPP12:   coeff = 16'd6554;
			BPP16:   coeff = 16'd8192;
			BPP20:   coeff = 16'd10923;
			BPP32:   coeff = 16'd16384;
			default: coeff = 16'd8192;
		endcase
	end

	// Bits per pixel minus one for the mask end
	always_comb begin
		case (color_depth_i)
			BPP4:    bpp = 7'd3;
			BPP8:    bpp = 7'd7;
			BPP12:   bpp = 7'd11;
			BPP16:   bpp = 7'd15;
			BPP20:   bpp = 7'd19;
			BPP32:   bpp = 7'd31;
			default: bpp = 7'd15;
		endcase
	end

	// Color bits per pixel as the offset of the color end
	always_comb begin
		case (color_depth_i)
			BPP4:    cbpp = 7'd3;
			BPP8:    cbpp = 7'd6;
			BPP12:   cbpp = 7'd9;
			BPP16:   cbpp = 7'd12;
			BPP20:   cbpp = 7'd15;
			BPP32:   cbpp = 7'd24;
			default: cbpp = 7'd12;
		endcase
	end

	// Bits actually filled by pixels
	// 12 and 20 bpp leave the top 8 bits spare
	always_comb begin
		case (color_depth_i)
			BPP12:   strip_bits = 8'd120;
			BPP20:   strip_bits = 8'd120;
			default: strip_bits = 8'(`GFX_STRIP_WIDTH);
		endcase
	end

	// ========================================================================
	// Horizontal position
	// ========================================================================

	// Strip number in the top half and strip fraction in the bottom half
	assign strip_num65k = gfx_addr_t'(x_coord_i) * gfx_addr_t'(coeff);

	// Rounding bias so the fraction never lands just under a pixel boundary
	assign strip_fract = strip_num65k[15:0] + 16'h007F;

	// Scale the fraction by the used strip bits
	assign ndx = 16'(strip_fract[15:7]) * 16'(strip_bits);

	assign mb_o = ndx[15:9];
	assign me_o = mb_o + bpp;
	assign ce_o = mb_o + cbpp;

	// ========================================================================
	// Line offset
	// ========================================================================

	// Strips per line only moves with a mode change
	// The register splits the two multiplies
	always_ff @(posedge clk) begin
		num_strips65k <= gfx_addr_t'(bmp_width_i) * gfx_addr_t'(coeff);
	end

	// Strips ahead of this pixel from the bitmap base
	assign strip_count = gfx_addr_t'(num_strips65k[31:16]) * gfx_addr_t'(y_coord_i)
		+ gfx_addr_t'(strip_num65k[31:16]);

	assign address_o = base_address_i + strip_count * gfx_addr_t'(`GFX_STRIP_BYTES);

endmodule

// File: gfx_pixel_merge.sv
// Inserts a pixel into a fetched strip for plots and pulls the pixel color out for reads
`include "gfx_settings.svh"

module gfx_pixel_merge (
	input  gfx_pkg::gfx_bitpos_t mb_i,
	input  gfx_pkg::gfx_bitpos_t me_i,
	input  gfx_pkg::gfx_bitpos_t ce_i,
	input  gfx_pkg::gfx_color_t  color_i,
	gfx_strip_if.merge           strip,
	output gfx_pkg::gfx_color_t  pixel_o
);
	import gfx_pkg::*;

	gfx_bitpos_t pix_len;
	gfx_bitpos_t col_len;
	gfx_strip_t  field_mask;
	gfx_strip_t  strip_mask;
	gfx_strip_t  color_shift;
	gfx_strip_t  color_mask;
	gfx_strip_t  rd_shift;

	// Field lengths, at most 32 bits so no wrap in 7 bits
	assign pix_len = me_i - mb_i + 7'd1;
	assign col_len = ce_i - mb_i + 7'd1;

	// ========================================================================
	// Plot path
	// ========================================================================

	// Ones from bit 0 up to the pixel width
	assign field_mask = ~({`GFX_STRIP_WIDTH{1'b1}} << pix_len);

	// Move the field onto the pixel slot
	assign strip_mask = field_mask << mb_i;

	// Color aligned to the slot, unused high color bits fall outside the mask
	assign color_shift = gfx_strip_t'(color_i) << mb_i;

	// Keep neighbours, replace only the slot
	assign strip.wr_data = (strip.rd_data & ~strip_mask) | (color_shift & strip_mask);

	// ========================================================================
	// Read path
	// ========================================================================

	// Color bits only, pad bits between ce and me are dropped
	assign color_mask = ~({`GFX_STRIP_WIDTH{1'b1}} << col_len);
	assign rd_shift   = strip.rd_data >> mb_i;

	// Zero-extended to the port width
	assign pixel_o = gfx_color_t'(rd_shift & color_mask);

endmodule

// File: gfx_pkg.sv
// Types shared by the pixel plot unit, imported by the modules and the strip interface
`include "gfx_settings.svh"

package gfx_pkg;

	// Byte address into the frame buffer
	typedef logic [31:0] gfx_addr_t;

	// Coordinate, or bitmap width in pixels
	typedef logic [`GFX_COORD_WIDTH-1:0] gfx_coord_t;

	// One whole strip of packed pixels
	typedef logic [`GFX_STRIP_WIDTH-1:0] gfx_strip_t;

	// Bit index inside a strip
	typedef logic [$clog2(`GFX_STRIP_WIDTH)-1:0] gfx_bitpos_t;

	// Pixel color as seen at the ports, low bits used
	typedef logic [31:0] gfx_color_t;

	// Index into the strip memory
	typedef logic [$clog2(`GFX_STRIP_DEPTH)-1:0] gfx_strip_idx_t;

	// Color depth codes, unknown codes are treated as 16 bpp
	typedef enum logic [2:0] {
		BPP4  = 3'd0,
		BPP8  = 3'd1,
		BPP12 = 3'd2,
		BPP16 = 3'd3,
		BPP20 = 3'd4,
		BPP32 = 3'd5
	} gfx_depth_e;

	// Command sequencer states
	typedef enum logic [2:0] {
		IDLE,
		CALC,
		FETCH,
		WRITE,
		DONE
	} gfx_ctrl_state_e;

endpackage

// File: gfx_plot_ctrl.sv
// Command sequencer that holds operands and runs each plot or read as one read-modify-write
`include "gfx_settings.svh"

module gfx_plot_ctrl (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 plot_i,
	input  logic                 read_i,
	input  gfx_pkg::gfx_coord_t  x_i,
	input  gfx_pkg::gfx_coord_t  y_i,
	input  gfx_pkg::gfx_color_t  color_i,
	input  gfx_pkg::gfx_addr_t   base_address_i,
	input  gfx_pkg::gfx_addr_t   address_i,
	input  gfx_pkg::gfx_bitpos_t mb_i,
	input  gfx_pkg::gfx_bitpos_t me_i,
	input  gfx_pkg::gfx_bitpos_t ce_i,
	input  gfx_pkg::gfx_color_t  pixel_i,
	gfx_strip_if.ctrl            strip,
	output gfx_pkg::gfx_coord_t  x_o,
	output gfx_pkg::gfx_coord_t  y_o,
	output gfx_pkg::gfx_color_t  color_o,
	output gfx_pkg::gfx_bitpos_t mb_o,
	output gfx_pkg::gfx_bitpos_t me_o,
	output gfx_pkg::gfx_bitpos_t ce_o,
	output logic                 busy_o,
	output logic                 done_o,
	output gfx_pkg::gfx_color_t  data_o
);
	import gfx_pkg::*;

	gfx_ctrl_state_e state;
	gfx_ctrl_state_e state_nxt;
	logic            accept;
	logic            is_plot;
	gfx_addr_t       address_q;
	gfx_addr_t       byte_ofs;
	gfx_strip_idx_t  strip_idx;

	// Free in IDLE and DONE, so back to back commands need no idle cycle
	assign busy_o = (state == CALC) || (state == FETCH) || (state == WRITE);
	assign done_o = (state == DONE);
	assign accept = !busy_o && (plot_i || read_i);

	// ========================================================================
	// State machine
	// ========================================================================

	always_comb begin
		case (state)
			IDLE:    state_nxt = accept ? CALC : IDLE;
			CALC:    state_nxt = FETCH;
			FETCH:   state_nxt = WRITE;
			WRITE:   state_nxt = DONE;
			DONE:    state_nxt = accept ? CALC : IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state   <= IDLE;
			is_plot <= 1'b0;
			data_o  <= '0;
		end else begin
			state <= state_nxt;
			// Plot has priority over a simultaneous read
			if (accept) begin
				is_plot <= plot_i;
			end
			// Read result holds until the next read finishes
			if (state == WRITE && !is_plot) begin
				data_o <= pixel_i;
			end
		end
	end

	// ========================================================================
	// Operands and calculated position
	// ========================================================================

	always_ff @(posedge clk) begin
		if (accept) begin
			x_o     <= x_i;
			y_o     <= y_i;
			color_o <= color_i;
		end
		// Calculator settles during CALC from the held coordinates
		if (state == CALC) begin
			address_q <= address_i;
			mb_o      <= mb_i;
			me_o      <= me_i;
			ce_o      <= ce_i;
		end
	end

	// Memory holds strips relative to the bitmap base
	assign byte_ofs  = address_q - base_address_i;
	assign strip_idx = gfx_strip_idx_t'(byte_ofs / gfx_addr_t'(`GFX_STRIP_BYTES));

	// Fetch in FETCH, write back in WRITE for plots only
	assign strip.rd_en  = (state == FETCH);
	assign strip.rd_idx = strip_idx;
	assign strip.wr_en  = (state == WRITE) && is_plot;
	assign strip.wr_idx = strip_idx;

endmodule

// File: gfx_plot_top.sv
// Pixel plot unit top level, joins controller, address calculator, merge datapath and strip memory
module gfx_plot_top (
	input  logic                clk,
	input  logic                rst_n_i,
	input  gfx_pkg::gfx_addr_t  base_address_i,
	input  gfx_pkg::gfx_coord_t bmp_width_i,
	input  gfx_pkg::gfx_depth_e color_depth_i,
	input  logic                plot_i,
	input  logic                read_i,
	input  gfx_pkg::gfx_coord_t x_i,
	input  gfx_pkg::gfx_coord_t y_i,
	input  gfx_pkg::gfx_color_t color_i,
	output logic                busy_o,
	output logic                done_o,
	output gfx_pkg::gfx_color_t data_o
);
	import gfx_pkg::*;

	// Held operands from the controller
	gfx_coord_t  x_hold;
	gfx_coord_t  y_hold;
	gfx_color_t  color_hold;

	// Calculator results, and their registered copies for the merge
	gfx_addr_t   calc_address;
	gfx_bitpos_t calc_mb;
	gfx_bitpos_t calc_me;
	gfx_bitpos_t calc_ce;
	gfx_bitpos_t mb_q;
	gfx_bitpos_t me_q;
	gfx_bitpos_t ce_q;
	gfx_color_t  pixel;

	gfx_strip_if strip ();

	gfx_plot_ctrl u_ctrl (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.plot_i         (plot_i),
		.read_i         (read_i),
		.x_i            (x_i),
		.y_i            (y_i),
		.color_i        (color_i),
		.base_address_i (base_address_i),
		.address_i      (calc_address),
		.mb_i           (calc_mb),
		.me_i           (calc_me),
		.ce_i           (calc_ce),
		.pixel_i        (pixel),
		.strip          (strip.ctrl),
		.x_o            (x_hold),
		.y_o            (y_hold),
		.color_o        (color_hold),
		.mb_o           (mb_q),
		.me_o           (me_q),
		.ce_o           (ce_q),
		.busy_o         (busy_o),
		.done_o         (done_o),
		.data_o         (data_o)
	);

	gfx_calc_address u_calc (
		.clk            (clk),
		.base_address_i (base_address_i),
		.color_depth_i  (color_depth_i),
		.bmp_width_i    (bmp_width_i),
		.x_coord_i      (x_hold),
		.y_coord_i      (y_hold),
		.address_o      (calc_address),
		.mb_o           (calc_mb),
		.me_o           (calc_me),
		.ce_o           (calc_ce)
	);

	gfx_pixel_merge u_merge (
		.mb_i    (mb_q),
		.me_i    (me_q),
		.ce_i    (ce_q),
		.color_i (color_hold),
		.strip   (strip.merge),
		.pixel_o (pixel)
	);

	gfx_strip_ram u_ram (
		.clk   (clk),
		.strip (strip.mem)
	);

endmodule

// File: gfx_settings.svh
// Widths and sizes shared by the pixel plot unit, included by every file that needs them
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

// Strip geometry of the frame buffer
`define GFX_STRIP_WIDTH 128
`define GFX_STRIP_BYTES 16

// Number of strips held in the internal strip memory
`define GFX_STRIP_DEPTH 1024

// Pixel coordinates and bitmap width in pixels
`define GFX_COORD_WIDTH 16

`endif

// File: gfx_strip_if.sv
// Strip memory access bundle joining the plot controller, the merge datapath and the memory
interface gfx_strip_if;
	import gfx_pkg::*;

	// Read side, data follows rd_en by one cycle
	logic           rd_en;
	gfx_strip_idx_t rd_idx;
	gfx_strip_t     rd_data;

	// Write side, takes effect on the edge where wr_en is high
	logic           wr_en;
	gfx_strip_idx_t wr_idx;
	gfx_strip_t     wr_data;

	// Controller owns the requests and indices
	modport ctrl (
		output rd_en, rd_idx, wr_en, wr_idx
	);

	// Merge datapath turns fetched strips into write strips
	modport merge (
		input  rd_data,
		output wr_data
	);

	// Memory serves both ports
	modport mem (
		input  rd_en, rd_idx, wr_en, wr_idx, wr_data,
		output rd_data
	);

endinterface

// File: gfx_strip_ram.sv
// Strip-wide frame buffer store with one registered read port and one write port
`include "gfx_settings.svh"

module gfx_strip_ram (
	input logic       clk,
	gfx_strip_if.mem  strip
);
	import gfx_pkg::*;

	// Contents are only defined once written
	gfx_strip_t mem [`GFX_STRIP_DEPTH];

	// Read data is available the cycle after the request
	always_ff @(posedge clk) begin
		if (strip.rd_en) begin
			strip.rd_data <= mem[strip.rd_idx];
		end
	end

	// Whole strip write, pixel masking is done upstream
	always_ff @(posedge clk) begin
		if (strip.wr_en) begin
			mem[strip.wr_idx] <= strip.wr_data;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it into sim.log and judges the log

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --top-module tb_gfx_plot -f build.f -o tb_gfx_plot_sim \
	&& ./obj_dir/tb_gfx_plot_sim 2>&1 | tee sim.log \
	|| { echo "Build or run error"; exit 1; }

grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
	|| { echo "Result: FAIL, no result line in sim.log"; exit 1; }
echo "Result: PASS"
exit 0

// File: tb_gfx_plot.sv
// Directed testbench for the pixel plot unit that runs as the simulation top with the file list
module tb_gfx_plot;
	import gfx_pkg::*;

	// Command budget of five cycles per command plus mode changes and reset
	localparam int CMD_COUNT      = 1 + 16 + 33 + 288 + 5 + 2;
	localparam int CMD_CYCLES     = 5;
	localparam int TIMEOUT_CYCLES = CMD_COUNT * CMD_CYCLES + 275;

	logic       clk;
	logic       rst_n_i;
	gfx_addr_t  base_address_i;
	gfx_coord_t bmp_width_i;
	gfx_depth_e color_depth_i;
	logic       plot_i;
	logic       read_i;
	gfx_coord_t x_i;
	gfx_coord_t y_i;
	gfx_color_t color_i;
	logic       busy_o;
	logic       done_o;
	gfx_color_t data_o;

	integer seed = 32'h808c;
	int     error_count = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;
	int     cycle_count = 0;

	gfx_plot_top UUT (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.base_address_i (base_address_i),
		.bmp_width_i    (bmp_width_i),
		.color_depth_i  (color_depth_i),
		.plot_i         (plot_i),
		.read_i         (read_i),
		.x_i            (x_i),
		.y_i            (y_i),
		.color_i        (color_i),
		.busy_o         (busy_o),
		.done_o         (done_o),
		.data_o         (data_o)
	);

	// 100 unit period
	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a command never finished", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// ========================================================================
	// Reference model and checks
	// ========================================================================

	// Color bits per pixel for each depth code
	function automatic int color_bits(input gfx_depth_e depth);
		case (depth)
			BPP4:    return 3;
			BPP8:    return 6;
			BPP12:   return 9;
			BPP16:   return 12;
			BPP20:   return 15;
			BPP32:   return 24;
			default: return 12;
		endcase
	endfunction

	// Read value keeps one bit more than the color bits of the written color
	function automatic gfx_color_t expected_pixel(input gfx_color_t color,
		input gfx_depth_e depth);
		gfx_color_t mask;
		mask = (32'h1 << (color_bits(depth) + 1)) - 32'h1;
		return color & mask;
	endfunction

	task automatic check_color(input string name, input gfx_color_t got, input gfx_color_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	// ========================================================================
	// Command drivers
	// ========================================================================

	// Mode inputs followed by time for the strips per line register
	task automatic set_mode(input gfx_addr_t base, input gfx_coord_t width, input gfx_depth_e depth);
		@(posedge clk);
		base_address_i <= base;
		bmp_width_i    <= width;
		color_depth_i  <= depth;
		repeat (2) @(posedge clk);
	endtask

	// Sampled on the falling edge away from the driving edge
	task automatic wait_done();
		@(negedge clk);
		while (!done_o) @(negedge clk);
	endtask

	task automatic plot_pixel(input gfx_coord_t x, input gfx_coord_t y, input gfx_color_t color);
		@(posedge clk);
		plot_i  <= 1'b1;
		x_i     <= x;
		y_i     <= y;
		color_i <= color;
		@(posedge clk);
		plot_i  <= 1'b0;
		wait_done();
	endtask

	// Result is taken while done_o is high
	task automatic read_pixel(input gfx_coord_t x, input gfx_coord_t y, output gfx_color_t value);
		@(posedge clk);
		read_i <= 1'b1;
		x_i    <= x;
		y_i    <= y;
		@(posedge clk);
		read_i <= 1'b0;
		wait_done();
		value = data_o;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic test_reset_timing();
		int errors_before;
		errors_before = error_count;
		@(negedge clk);
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("done_o", done_o, 1'b0);
		check_color("data_o", data_o, 32'h0);
		@(posedge clk);
		plot_i  <= 1'b1;
		x_i     <= 16'd1;
		y_i     <= 16'd0;
		color_i <= 32'h0000_0123;
		// Accepting edge
		@(posedge clk);
		plot_i <= 1'b0;
		// Busy for three cycles and then one done cycle
		for (int k = 0; k < 5; k++) begin
			@(negedge clk);
			check_flag("busy_o", busy_o, k < 3);
			check_flag("done_o", done_o, k == 3);
		end
		report_test("reset and timing", errors_before);
	endtask

	task automatic test_readback_16bpp();
		int         errors_before;
		gfx_color_t colors [8];
		gfx_color_t value;
		errors_before = error_count;
		set_mode(32'h0, 16'd64, BPP16);
		for (int i = 0; i < 8; i++) begin
			colors[i] = $random(seed);
			plot_pixel(gfx_coord_t'(i * 5), gfx_coord_t'(i), colors[i]);
		end
		for (int i = 0; i < 8; i++) begin
			read_pixel(gfx_coord_t'(i * 5), gfx_coord_t'(i), value);
			check_color($sformatf("data_o (%0d,%0d)", i * 5, i), value,
				expected_pixel(colors[i], BPP16));
		end
		report_test("plot and read back at 16 bpp", errors_before);
	endtask

	// Sixteen 8 bpp pixels from x = 16 fill strip 1 of row 3
	task automatic test_neighbors();
		int         errors_before;
		gfx_color_t colors [16];
		gfx_color_t value;
		errors_before = error_count;
		set_mode(32'h0, 16'd64, BPP8);
		for (int i = 0; i < 16; i++) begin
			colors[i] = $random(seed);
			plot_pixel(gfx_coord_t'(16 + i), 16'd3, colors[i]);
		end
		// New value differs inside the color bits
		colors[5] = colors[5] ^ 32'h0000_002A;
		plot_pixel(16'd21, 16'd3, colors[5]);
		for (int i = 0; i < 16; i++) begin
			read_pixel(gfx_coord_t'(16 + i), 16'd3, value);
			check_color($sformatf("data_o (%0d,3)", 16 + i), value,
				expected_pixel(colors[i], BPP8));
		end
		report_test("neighbors unchanged", errors_before);
	endtask

	// All pixels of a depth go in before any is read back
	task automatic test_all_depths();
		int         errors_before;
		gfx_depth_e depth_list [6];
		gfx_color_t colors [24];
		gfx_color_t value;
		errors_before = error_count;
		depth_list = '{BPP4, BPP8, BPP12, BPP16, BPP20, BPP32};
		for (int d = 0; d < 6; d++) begin
			set_mode(32'h0, 16'd64, depth_list[d]);
			for (int i = 0; i < 24; i++) begin
				colors[i] = $random(seed);
				plot_pixel(gfx_coord_t'(i % 12), gfx_coord_t'(i / 12), colors[i]);
			end
			for (int i = 0; i < 24; i++) begin
				read_pixel(gfx_coord_t'(i % 12), gfx_coord_t'(i / 12), value);
				check_color($sformatf("data_o depth %0d (%0d,%0d)", d, i % 12, i / 12),
					value, expected_pixel(colors[i], depth_list[d]));
			end
		end
		report_test("every depth code", errors_before);
	endtask

	// Strips are indexed relative to the bitmap base so a base move keeps the placement
	task automatic test_base_offset();
		int         errors_before;
		gfx_color_t color_a;
		gfx_color_t color_b;
		gfx_color_t value;
		errors_before = error_count;
		color_a = $random(seed);
		color_b = color_a ^ 32'h0000_0A5A;
		set_mode(32'h0, 16'd64, BPP16);
		plot_pixel(16'd10, 16'd5, color_a);
		set_mode(32'd1600, 16'd64, BPP16);
		read_pixel(16'd10, 16'd5, value);
		check_color("data_o base 1600 first", value, expected_pixel(color_a, BPP16));
		plot_pixel(16'd10, 16'd5, color_b);
		read_pixel(16'd10, 16'd5, value);
		check_color("data_o base 1600 second", value, expected_pixel(color_b, BPP16));
		set_mode(32'h0, 16'd64, BPP16);
		read_pixel(16'd10, 16'd5, value);
		check_color("data_o base 0", value, expected_pixel(color_b, BPP16));
		report_test("base address offset", errors_before);
	endtask

	task automatic test_busy_strobe();
		int         errors_before;
		int         pulses;
		gfx_color_t color;
		gfx_color_t value;
		errors_before = error_count;
		color = $random(seed);
		@(posedge clk);
		plot_i  <= 1'b1;
		x_i     <= 16'd7;
		y_i     <= 16'd2;
		color_i <= color;
		// Plot accepted here
		// Read strobe lands one cycle later while busy
		@(posedge clk);
		plot_i <= 1'b0;
		read_i <= 1'b1;
		x_i    <= 16'd0;
		y_i    <= 16'd0;
		@(posedge clk);
		read_i <= 1'b0;
		pulses = 0;
		repeat (8) begin
			@(negedge clk);
			if (done_o) pulses++;
		end
		if (pulses != 1) begin
			$display("Error: %0d done_o pulses after a read strobe while busy, one expected",
				pulses);
			error_count++;
		end
		read_pixel(16'd7, 16'd2, value);
		check_color("data_o (7,2)", value, expected_pixel(color, BPP16));
		report_test("ignored strobe while busy", errors_before);
	endtask

	// ========================================================================
	// Sequence
	// ========================================================================

	initial begin
		rst_n_i        <= 1'b0;
		plot_i         <= 1'b0;
		read_i         <= 1'b0;
		x_i            <= '0;
		y_i            <= '0;
		color_i        <= '0;
		base_address_i <= '0;
		bmp_width_i    <= 16'd64;
		color_depth_i  <= BPP16;
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		test_reset_timing();
		test_readback_16bpp();
		test_neighbors();
		test_all_depths();
		test_base_offset();
		test_busy_strobe();
		$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
